// ==== loopCore.f ====
cpuPkg.sv
wbPkg.sv
loopCounter.sv
accumulatorUnit.sv
sequencer.sv
loopCore.sv
tbMemModel.sv
tbLoopCore.sv

// ==== tbLoopCore.sv ====
`timescale 1ns/1ps

module tbLoopCore;
    import cpuPkg::*;
    import wbPkg::*;

    localparam addrT ResetPc       = 8'h10;
    localparam int   ClkPeriod     = 4;
    localparam int   MaxWait       = 3;
    localparam int   ProgLen       = 31;
    localparam int   TimeoutCycles = ProgLen * 40 * (MaxWait + 1);
    localparam int   NumStores     = 2;
    localparam int   DrainCycles   = 100;
    localparam int   MinNoopRounds = 3;

    localparam wordT LimitM    = 16'd5;
    localparam wordT LimitK    = 16'd7;
    localparam wordT LimitN    = 16'd2;   // Nonzero keeps the final loop running
    localparam addrT LimitMAdr = 8'h80;
    localparam addrT LimitKAdr = 8'h81;
    localparam addrT LimitNAdr = 8'h82;
    localparam addrT ZeroAdr   = 8'h83;

    localparam addrT StoreAdr [NumStores] = '{8'h90, 8'h91};

    localparam addrT SkipJmpAdr  = ResetPc + 8'd3;
    localparam addrT NoopLoopAdr = ResetPc + 8'd28;

    localparam instrT Program [ProgLen] = '{
        8'h20, ZeroAdr,           // COPY M with limit 0
        8'h43,                    // RESET all
        8'h10, ResetPc,           // JMP M must fall through
        8'h20, LimitMAdr,
        8'h21, LimitKAdr,
        8'h22, LimitNAdr,
        8'h43,
        8'h41,                    // RESET K at the top of the outer loop
        8'h31,                    // INC K opens the inner loop
        8'h51,                    // ADD K
        8'h11, ResetPc + 8'd13,
        8'h30,                    // INC M
        8'h10, ResetPc + 8'd12,
        8'h60, StoreAdr[0],       // STORE the loop sum
        8'h32,
        8'h42,                    // RESET N
        8'h52,
        8'h50,                    // ADD M
        8'h60, StoreAdr[1],
        8'h00,                    // Endless NOOP loop on N
        8'h12, NoopLoopAdr
    };

    logic       Clk;
    logic       arstN;
    wbInstrReqT instrReq;
    wbInstrRspT instrRsp;
    wbDataReqT  dataReq;
    wbDataRspT  dataRsp;

    wordT       expStore [NumStores];
    int         storeCount;
    int         noopRounds;
    logic       storeAck;
    logic       fetchSeen;
    addrT       lastAckAdr;   // Address of the last acked instruction read
    wbInstrReqT lastInstrReq;
    wbDataReqT  lastDataReq;
    logic       instrHold;
    logic       dataHold;

    loopCore #(.ResetPc(ResetPc)) loopCore_i (
        .Clk(Clk), .arstN(arstN),
        .instrReq(instrReq), .instrRsp(instrRsp),
        .dataReq(dataReq), .dataRsp(dataRsp)
    );

    tbMemModel #(.MaxWait(MaxWait)) memModel_i (
        .Clk(Clk), .arstN(arstN),
        .instrReq(instrReq), .instrRsp(instrRsp),
        .dataReq(dataReq), .dataRsp(dataRsp)
    );

    task automatic stopWithFailure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        stopWithFailure();
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        stopWithFailure();
    endtask

    task automatic loadMemories();
        for (int i = 0; i < ProgLen; i++) begin
            memModel_i.rom[addrT'(ResetPc + i)] = Program[i];
        end
        memModel_i.ram[LimitMAdr] = LimitM;
        memModel_i.ram[LimitKAdr] = LimitK;
        memModel_i.ram[LimitNAdr] = LimitN;
        memModel_i.ram[ZeroAdr]   = '0;
    endtask

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    assign storeAck = dataReq.stb && dataReq.we && dataRsp.ack;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            storeCount   <= 0;
            noopRounds   <= 0;
            fetchSeen    <= 1'b0;
            lastAckAdr   <= ~SkipJmpAdr;
            lastInstrReq <= '0;
            lastDataReq  <= '0;
            instrHold    <= 1'b0;
            dataHold     <= 1'b0;
        end else begin
            if (storeAck) begin
                storeCount <= storeCount + 1;
            end
            if (instrReq.stb) begin
                fetchSeen <= 1'b1;
            end
            if (instrReq.stb && instrRsp.ack) begin
                lastAckAdr <= instrReq.adr;
                if (storeCount == NumStores && instrReq.adr == NoopLoopAdr) begin
                    noopRounds <= noopRounds + 1;
                end
            end
            lastInstrReq <= instrReq;
            lastDataReq  <= dataReq;
            instrHold    <= instrReq.stb && !instrRsp.ack;   // Waiting for ack
            dataHold     <= dataReq.stb && !dataRsp.ack;
        end
    end

    // Outputs settle after the rising edge
    assert property (@(negedge Clk) !arstN |-> !instrReq.cyc && !dataReq.cyc)
        else reportMismatch("instrReq.cyc/dataReq.cyc", 0,
                            $sampled({instrReq.cyc, dataReq.cyc}));
    assert property (@(posedge Clk) disable iff (!arstN)
        instrReq.stb && !fetchSeen |-> instrReq.adr == ResetPc)
        else reportMismatch("instrReq.adr", ResetPc, $sampled(instrReq.adr));
    assert property (@(posedge Clk) disable iff (!arstN) instrReq.stb |-> instrReq.cyc)
        else reportMismatch("instrReq.cyc", 1, $sampled(instrReq.cyc));
    assert property (@(posedge Clk) disable iff (!arstN) dataReq.stb |-> dataReq.cyc)
        else reportMismatch("dataReq.cyc", 1, $sampled(dataReq.cyc));
    assert property (@(posedge Clk) disable iff (!arstN) instrHold |-> instrReq == lastInstrReq)
        else reportMismatch("instrReq", $sampled(lastInstrReq), $sampled(instrReq));
    assert property (@(posedge Clk) disable iff (!arstN) dataHold |-> dataReq == lastDataReq)
        else reportMismatch("dataReq", $sampled(lastDataReq), $sampled(dataReq));

    // Untaken JMP skips its target byte
    assert property (@(posedge Clk) disable iff (!arstN)
        $rose(instrReq.stb) && lastAckAdr == SkipJmpAdr |-> instrReq.adr == SkipJmpAdr + 8'd2)
        else reportMismatch("instrReq.adr", SkipJmpAdr + 8'd2, $sampled(instrReq.adr));

    assert property (@(posedge Clk) disable iff (!arstN) storeAck |-> storeCount < NumStores)
        else abortRun("Data write seen after the last STORE of the program");
    assert property (@(posedge Clk) disable iff (!arstN)
        storeAck && storeCount < NumStores |-> dataReq.adr == StoreAdr[storeCount])
        else reportMismatch("dataReq.adr", $sampled(StoreAdr[storeCount]),
                            $sampled(dataReq.adr));
    assert property (@(posedge Clk) disable iff (!arstN)
        storeAck && storeCount < NumStores |-> dataReq.dat == expStore[storeCount])
        else reportMismatch("dataReq.dat", $sampled(expStore[storeCount]),
                            $sampled(dataReq.dat));
    assert property (@(posedge Clk) disable iff (!arstN)
        storeCount == NumStores && instrReq.stb |->
            instrReq.adr >= NoopLoopAdr && instrReq.adr <= NoopLoopAdr + 8'd2)
        else reportMismatch("instrReq.adr", NoopLoopAdr, $sampled(instrReq.adr));

    initial begin
        int kSum;
        arstN       = 1'b0;
        kSum        = int'(LimitK) * (int'(LimitK) + 1) / 2;
        expStore[0] = wordT'(int'(LimitM) * kSum);   // Modulo 2**16
        expStore[1] = wordT'(expStore[0] + LimitM);  // ADD N adds zero after RESET N
        repeat (5) @(posedge Clk);
        loadMemories();
        @(negedge Clk);
        arstN = 1'b1;
        wait (storeCount == NumStores);
        repeat (DrainCycles) @(posedge Clk);
        if (noopRounds >= MinNoopRounds) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abortRun("Final NOOP loop is not running after the last STORE");
        end
    end

    // Worst case for the program at maximum wait states
    initial begin
        #(TimeoutCycles * ClkPeriod);
        abortRun("Watchdog timeout before the program finished");
    end

endmodule

// ==== tbMemModel.sv ====
`timescale 1ns/1ps

module tbMemModel #(
    parameter int MaxWait = 3
) (
    input  logic              Clk,
    input  logic              arstN,
    input  wbPkg::wbInstrReqT instrReq,
    output wbPkg::wbInstrRspT instrRsp,
    input  wbPkg::wbDataReqT  dataReq,
    output wbPkg::wbDataRspT  dataRsp
);
    import cpuPkg::*;

    instrT  rom [256];
    wordT   ram [256];
    integer seed = 27;
    int     instrWait;
    int     dataWait;
    logic   instrBusy;   // Wait count already drawn for this transfer
    logic   dataBusy;

    // Unwritten ROM decodes as NOOP
    initial begin
        instrRsp = '0;
        dataRsp  = '0;
        for (int a = 0; a < 256; a++) begin
            rom[a] = {4'h0, a[7:4] ^ a[3:0]};
            ram[a] = {a[7:0], ~a[7:0]};   // Pattern over the whole address
        end
    end

    // Responses only change on the falling edge
    always @(negedge Clk or negedge arstN) begin
        if (!arstN) begin
            instrRsp  = '0;
            dataRsp   = '0;
            instrBusy = 1'b0;
            dataBusy  = 1'b0;
            instrWait = 0;
            dataWait  = 0;
        end else begin
            if (instrRsp.ack) begin
                instrRsp.ack = 1'b0;   // Ack lasts one cycle
                instrBusy    = 1'b0;
            end else if (instrReq.cyc && instrReq.stb) begin
                if (!instrBusy) begin
                    instrBusy = 1'b1;
                    instrWait = $unsigned($random(seed)) % (MaxWait + 1);
                end
                if (instrWait == 0) begin
                    instrRsp.ack = 1'b1;
                    instrRsp.dat = rom[instrReq.adr];
                end else begin
                    instrWait--;
                end
            end
            if (dataRsp.ack) begin
                dataRsp.ack = 1'b0;
                dataBusy    = 1'b0;
            end else if (dataReq.cyc && dataReq.stb) begin
                if (!dataBusy) begin
                    dataBusy = 1'b1;
                    dataWait = $unsigned($random(seed)) % (MaxWait + 1);
                end
                if (dataWait == 0) begin
                    dataRsp.ack = 1'b1;
                    if (dataReq.we) begin
                        ram[dataReq.adr] = dataReq.dat;
                    end else begin
                        dataRsp.dat = ram[dataReq.adr];
                    end
                end else begin
                    dataWait--;
                end
            end
        end
    end

endmodule

// ==== loopCore.sv ====
`timescale 1ns/1ps

module loopCore #(
    parameter cpuPkg::addrT ResetPc = '0
) (
    input  logic               Clk,
    input  logic               arstN,
    output wbPkg::wbInstrReqT  instrReq,
    input  wbPkg::wbInstrRspT  instrRsp,
    output wbPkg::wbDataReqT   dataReq,
    input  wbPkg::wbDataRspT   dataRsp
);
    import cpuPkg::*;

    loopCtrlT              loopCtrl;
    wordT                  indexes [NumLoops];
    logic [NumLoops-1:0]   dones;
    logic                  selDone;
    wordT                  acc;

    sequencer #(
        .ResetPc (ResetPc)
    ) sequencer_i (
        .Clk      (Clk),
        .arstN    (arstN),
        .instrReq (instrReq),
        .instrRsp (instrRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp),
        .selDone  (selDone),
        .acc      (acc),
        .loopCtrl (loopCtrl)
    );

    // M, K and N counters in selector order
    for (genvar i = 0; i < NumLoops; i++) begin : genLoop
        loopCounter #(
            .LoopId (loopSelT'(i))
        ) loopCounter_i (
            .Clk      (Clk),
            .arstN    (arstN),
            .loopCtrl (loopCtrl),
            .index    (indexes[i]),
            .done     (dones[i])
        );
    end

    accumulatorUnit accumulatorUnit_i (
        .Clk      (Clk),
        .arstN    (arstN),
        .loopCtrl (loopCtrl),
        .indexes  (indexes),
        .dones    (dones),
        .selDone  (selDone),
        .acc      (acc)
    );

endmodule

// ==== sequencer.sv ====
`timescale 1ns/1ps

module sequencer #(
    parameter cpuPkg::addrT ResetPc = '0
) (
    input  logic               Clk,
    input  logic               arstN,
    output wbPkg::wbInstrReqT  instrReq,
    input  wbPkg::wbInstrRspT  instrRsp,
    output wbPkg::wbDataReqT   dataReq,
    input  wbPkg::wbDataRspT   dataRsp,
    input  logic               selDone,
    input  cpuPkg::wordT       acc,
    output cpuPkg::loopCtrlT   loopCtrl
);
    import cpuPkg::*;

    seqStateT state;
    addrT     pc;
    instrT    ir;
    addrT     argAddr;    // Immediate data address of COPY and STORE
    wordT     dataWord;   // Limit read by COPY
    opcodeT   opcode;
    loopSelT  sel;

    assign opcode = opcodeT'(ir[7:4]);
    assign sel    = loopSelT'(ir[1:0]);

    // Bus requests are registered, a transfer ends the cycle after ack
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state    <= FetchOp;
            pc       <= ResetPc;
            ir       <= '0;
            instrReq <= '0;
            dataReq  <= '0;
        end else begin
            case (state)
                FetchOp: begin
                    if (!instrReq.cyc) begin
                        instrReq.cyc <= 1'b1;
                        instrReq.stb <= 1'b1;
                        instrReq.adr <= pc;
                    end else if (instrRsp.ack) begin
                        instrReq.cyc <= 1'b0;
                        instrReq.stb <= 1'b0;
                        ir           <= instrRsp.dat;
                        pc           <= pc + 1'b1;
                        state        <= Decode;
                    end
                end
                Decode: begin
                    case (opcode)
                        JMP: begin
                            if (selDone) begin
                                pc    <= pc + 1'b1;   // Skip the target byte
                                state <= FetchOp;
                            end else begin
                                state <= FetchArg;
                            end
                        end
                        COPY, STORE:     state <= FetchArg;
                        INC, RESET, ADD: state <= Execute;
                        default:         state <= FetchOp;   // NOOP and unused codes
                    endcase
                end
                FetchArg: begin
                    if (!instrReq.cyc) begin
                        instrReq.cyc <= 1'b1;
                        instrReq.stb <= 1'b1;
                        instrReq.adr <= pc;
                    end else if (instrRsp.ack) begin
                        instrReq.cyc <= 1'b0;
                        instrReq.stb <= 1'b0;
                        if (opcode == JMP) begin
                            pc    <= instrRsp.dat;   // Jump taken
                            state <= FetchOp;
                        end else begin
                            pc    <= pc + 1'b1;
                            state <= (opcode == COPY) ? DataRead : DataWrite;
                        end
                    end
                end
                DataRead: begin
                    if (!dataReq.cyc) begin
                        dataReq.cyc <= 1'b1;
                        dataReq.stb <= 1'b1;
                        dataReq.we  <= 1'b0;
                        dataReq.adr <= argAddr;
                    end else if (dataRsp.ack) begin
                        dataReq.cyc <= 1'b0;
                        dataReq.stb <= 1'b0;
                        state       <= Execute;
                    end
                end
                DataWrite: begin
                    if (!dataReq.cyc) begin
                        dataReq.cyc <= 1'b1;
                        dataReq.stb <= 1'b1;
                        dataReq.we  <= 1'b1;
                        dataReq.adr <= argAddr;
                        dataReq.dat <= acc;
                    end else if (dataRsp.ack) begin
                        dataReq.cyc <= 1'b0;
                        dataReq.stb <= 1'b0;
                        dataReq.we  <= 1'b0;
                        state       <= FetchOp;
                    end
                end
                Execute: state <= FetchOp;   // Strobe goes out this cycle
                default: state <= FetchOp;
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge Clk) begin
        if (state == FetchArg && instrReq.cyc && instrRsp.ack) begin
            argAddr <= instrRsp.dat;
        end
        if (state == DataRead && dataReq.cyc && dataRsp.ack) begin
            dataWord <= dataRsp.dat;
        end
    end

    // One strobe, for one cycle, only in Execute
    always_comb begin
        loopCtrl          = '0;
        loopCtrl.sel      = sel;
        loopCtrl.loadData = dataWord;
        if (state == Execute) begin
            case (opcode)
                COPY: loopCtrl.loadLimit = 1'b1;
                INC:  loopCtrl.inc       = 1'b1;
                RESET: begin
                    if (sel == LoopAll) begin
                        loopCtrl.clearAll = 1'b1;
                    end else begin
                        loopCtrl.clear = 1'b1;
                    end
                end
                ADD:     loopCtrl.add = 1'b1;
                default: loopCtrl.add = 1'b0;
            endcase
        end
    end

    assert property (@(posedge Clk) disable iff (!arstN)
        (instrReq.stb |-> instrReq.cyc) and (dataReq.stb |-> dataReq.cyc));

    // Wishbone classic, request frozen until ack
    assert property (@(posedge Clk) disable iff (!arstN)
        instrReq.stb && !instrRsp.ack |=> $stable(instrReq));

    assert property (@(posedge Clk) disable iff (!arstN)
        dataReq.stb && !dataRsp.ack |=> $stable(dataReq));

endmodule

// ==== accumulatorUnit.sv ====
`timescale 1ns/1ps

module accumulatorUnit (
    input  logic                         Clk,
    input  logic                         arstN,
    input  cpuPkg::loopCtrlT             loopCtrl,
    input  cpuPkg::wordT                 indexes [cpuPkg::NumLoops],
    input  logic [cpuPkg::NumLoops-1:0]  dones,
    output logic                         selDone,
    output cpuPkg::wordT                 acc
);
    import cpuPkg::*;

    wordT selIndex;

    // Index and done flag of the selected loop
    always_comb begin
        selIndex = '0;
        selDone  = 1'b1;   // No counter behind LoopAll, JMP falls through
        if (loopCtrl.sel != LoopAll) begin
            selIndex = indexes[loopCtrl.sel];
            selDone  = dones[loopCtrl.sel];
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            acc <= '0;
        end else if (loopCtrl.clearAll) begin
            acc <= '0;
        end else if (loopCtrl.add) begin
            acc <= acc + selIndex;   // Modulo 2**16
        end
    end

    // ADD always names one of the three loops
    assert property (@(posedge Clk) disable iff (!arstN)
        loopCtrl.add |-> loopCtrl.sel != LoopAll);

endmodule

// ==== loopCounter.sv ====
`timescale 1ns/1ps

module loopCounter #(
    parameter cpuPkg::loopSelT LoopId = cpuPkg::LoopM
) (
    input  logic             Clk,
    input  logic             arstN,
    input  cpuPkg::loopCtrlT loopCtrl,
    output cpuPkg::wordT     index,
    output logic             done
);
    import cpuPkg::*;

    wordT limit;
    logic hit;   // This loop is addressed

    assign hit = (loopCtrl.sel == LoopId);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            limit <= '0;
            index <= '0;
        end else begin
            if (hit && loopCtrl.loadLimit) begin
                limit <= loopCtrl.loadData;
            end
            if (loopCtrl.clearAll || (hit && loopCtrl.clear)) begin
                index <= '0;
            end else if (hit && loopCtrl.inc) begin
                index <= index + 1'b1;   // Wraps at 16 bits
            end
        end
    end

    assign done = (index == limit);   // JMP falls through when set

    // The sequencer never clears and steps an index in the same cycle
    assert property (@(posedge Clk) disable iff (!arstN)
        !(loopCtrl.inc && (loopCtrl.clear || loopCtrl.clearAll)));

endmodule

// ==== wbPkg.sv ====
package wbPkg;

    // Instruction port, read only
    typedef struct packed {
        logic         cyc;
        logic         stb;
        cpuPkg::addrT adr;
    } wbInstrReqT;

    typedef struct packed {
        logic          ack;
        cpuPkg::instrT dat;
    } wbInstrRspT;

    // Data port
    typedef struct packed {
        logic         cyc;
        logic         stb;
        logic         we;
        cpuPkg::addrT adr;
        cpuPkg::wordT dat;   // Write data
    } wbDataReqT;

    typedef struct packed {
        logic         ack;
        cpuPkg::wordT dat;   // Read data, valid with ack
    } wbDataRspT;

endpackage

// ==== cpuPkg.sv ====
package cpuPkg;

    typedef logic [7:0]  instrT;   // Instruction or operand byte
    typedef logic [7:0]  addrT;    // Program and data address
    typedef logic [15:0] wordT;    // Limits, indexes, accumulator, memory data

    // Upper nibble of an instruction
    typedef enum logic [3:0] {
        NOOP  = 4'd0,
        JMP   = 4'd1,
        COPY  = 4'd2,
        INC   = 4'd3,
        RESET = 4'd4,
        ADD   = 4'd5,
        STORE = 4'd6
    } opcodeT;

    // Loop select from the lower nibble
    typedef enum logic [1:0] {
        LoopM   = 2'd0,
        LoopK   = 2'd1,
        LoopN   = 2'd2,
        LoopAll = 2'd3   // Only meaningful with RESET
    } loopSelT;

    localparam int NumLoops = 3;

    typedef enum logic [2:0] {
        FetchOp,
        Decode,
        FetchArg,
        DataRead,
        DataWrite,
        Execute
    } seqStateT;

    // Strobes from the sequencer to the counters and the accumulator
    typedef struct packed {
        loopSelT sel;
        logic    loadLimit;
        logic    inc;
        logic    clear;
        logic    clearAll;
        logic    add;
        wordT    loadData;
    } loopCtrlT;

endpackage
